// File: rtl/wb_pkg.sv
package wb_pkg;

    // data word width
    localparam int XLEN = 32;

    // general register address width and count
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS = 32;

    // retire opcode carried by each lane of a bundle
    typedef enum logic [2:0] {
        WB_NOP  = 3'd0,
        // write a general register
        WB_GPR  = 3'd1,
        // load HI or LO from the data word
        WB_MTHI = 3'd2,
        WB_MTLO = 3'd3,
        // HI:LO from the product
        WB_MULT = 3'd4,
        // accumulate product into old HI:LO
        WB_MADD = 3'd5,
        WB_MSUB = 3'd6
    } wb_op_t;

endpackage

// File: rtl/wb_control.sv
`timescale 1ns/10ps

module wb_control (
    input  logic clk,
    input  logic reset,
    input  logic i_req,
    output logic o_ack,
    output logic o_commit
);

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_COMMIT = 2'd1,
        ST_ACK    = 2'd2
    } state_t;

    state_t state;
    state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (i_req) begin
                    state_next = ST_COMMIT;
                end
            end
            // one cycle only, writes land at the end of it
            ST_COMMIT: begin
                state_next = ST_ACK;
            end
            // hold ack until the producer drops req
            ST_ACK: begin
                if (!i_req) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // both outputs decode straight from the state register
    assign o_commit = (state == ST_COMMIT);
    assign o_ack = (state == ST_ACK);

    // a bundle commits once per handshake
    a_single_commit: assert property (@(posedge clk) disable iff (reset)
        o_commit |=> !o_commit);

    // ack only answers a live request
    a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(o_ack) |-> $past(i_req));

endmodule

// File: rtl/hilo_unit.sv
`timescale 1ns/10ps

module hilo_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        i_commit,
    input  wb_pkg::wb_op_t              i_op0,
    input  wb_pkg::wb_op_t              i_op1,
    input  logic [wb_pkg::XLEN-1:0]     i_data0,
    input  logic [wb_pkg::XLEN-1:0]     i_data1,
    input  logic [2*wb_pkg::XLEN-1:0]   i_prod0,
    input  logic [2*wb_pkg::XLEN-1:0]   i_prod1,
    output logic [wb_pkg::XLEN-1:0]     o_hi,
    output logic [wb_pkg::XLEN-1:0]     o_lo
);

    logic [wb_pkg::XLEN-1:0]   hi_q;
    logic [wb_pkg::XLEN-1:0]   lo_q;
    logic [wb_pkg::XLEN-1:0]   hi_next;
    logic [wb_pkg::XLEN-1:0]   lo_next;
    logic [2*wb_pkg::XLEN-1:0] hilo_old;

    wb_pkg::wb_op_t            lane_op [2];
    logic [wb_pkg::XLEN-1:0]   lane_data [2];
    logic [2*wb_pkg::XLEN-1:0] lane_prod [2];
    logic [2*wb_pkg::XLEN-1:0] lane_cand [2];
    logic [1:0]                hi_we;
    logic [1:0]                lo_we;

    assign lane_op[0] = i_op0;
    assign lane_op[1] = i_op1;
    assign lane_data[0] = i_data0;
    assign lane_data[1] = i_data1;
    assign lane_prod[0] = i_prod0;
    assign lane_prod[1] = i_prod1;

    // both lanes see the pre-bundle pair, no chaining
    assign hilo_old = {hi_q, lo_q};

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            hi_we[l] = 1'b0;
            lo_we[l] = 1'b0;
            lane_cand[l] = hilo_old;
            case (lane_op[l])
                wb_pkg::WB_MTHI: begin
                    hi_we[l] = 1'b1;
                    lane_cand[l] = {lane_data[l], lo_q};
                end
                wb_pkg::WB_MTLO: begin
                    lo_we[l] = 1'b1;
                    lane_cand[l] = {hi_q, lane_data[l]};
                end
                wb_pkg::WB_MULT: begin
                    {hi_we[l], lo_we[l]} = 2'b11;
                    lane_cand[l] = lane_prod[l];
                end
                wb_pkg::WB_MADD: begin
                    {hi_we[l], lo_we[l]} = 2'b11;
                    lane_cand[l] = hilo_old + lane_prod[l];
                end
                wb_pkg::WB_MSUB: begin
                    {hi_we[l], lo_we[l]} = 2'b11;
                    lane_cand[l] = hilo_old - lane_prod[l];
                end
                default: begin
                end
            endcase
        end
    end

    // younger lane 1 overrides lane 0 per half
    always_comb begin
        hi_next = hi_q;
        lo_next = lo_q;
        for (int l = 0; l < 2; l++) begin
            if (hi_we[l]) begin
                hi_next = lane_cand[l][2*wb_pkg::XLEN-1:wb_pkg::XLEN];
            end
            if (lo_we[l]) begin
                lo_next = lane_cand[l][wb_pkg::XLEN-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (i_commit) begin
            hi_q <= hi_next;
            lo_q <= lo_next;
        end
    end

    assign o_hi = hi_q;
    assign o_lo = lo_q;

    // only a commit cycle may change HI or LO
    a_hilo_hold: assert property (@(posedge clk) disable iff (reset)
        !i_commit |=> $stable(o_hi) && $stable(o_lo));

endmodule

// File: rtl/gpr_file.sv
`timescale 1ns/10ps

module gpr_file (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            i_commit,
    input  wb_pkg::wb_op_t                  i_op0,
    input  wb_pkg::wb_op_t                  i_op1,
    input  logic [wb_pkg::REG_ADDR_W-1:0]   i_rdst0,
    input  logic [wb_pkg::REG_ADDR_W-1:0]   i_rdst1,
    input  logic [wb_pkg::XLEN-1:0]         i_data0,
    input  logic [wb_pkg::XLEN-1:0]         i_data1,
    input  logic [wb_pkg::REG_ADDR_W-1:0]   i_raddr,
    output logic [wb_pkg::XLEN-1:0]         o_rdata
);

    logic [wb_pkg::XLEN-1:0] regs [wb_pkg::NUM_REGS];
    logic                    we0;
    logic                    we1;

    // register 0 is never a write target
    assign we0 = i_commit && (i_op0 == wb_pkg::WB_GPR) && (i_rdst0 != '0);
    assign we1 = i_commit && (i_op1 == wb_pkg::WB_GPR) && (i_rdst1 != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < wb_pkg::NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            if (we0) begin
                regs[i_rdst0] <= i_data0;
            end
            // lane 1 last, so it wins on a shared target
            if (we1) begin
                regs[i_rdst1] <= i_data1;
            end
        end
    end

    assign o_rdata = regs[i_raddr];

    // entry 0 stays zero across all commits
    a_r0_zero: assert property (@(posedge clk) disable iff (reset)
        (i_raddr == '0) |-> (o_rdata == '0));

endmodule

// File: rtl/wb_top.sv
`timescale 1ns/10ps

module wb_top (
    input  logic                            clk,
    input  logic                            reset,

    // four-phase bundle handshake
    input  logic                            i_req,
    output logic                            o_ack,

    // lane 0 is older, lane 1 younger
    input  wb_pkg::wb_op_t                  i_op0,
    input  wb_pkg::wb_op_t                  i_op1,
    input  logic [wb_pkg::REG_ADDR_W-1:0]   i_rdst0,
    input  logic [wb_pkg::REG_ADDR_W-1:0]   i_rdst1,
    input  logic [wb_pkg::XLEN-1:0]         i_data0,
    input  logic [wb_pkg::XLEN-1:0]         i_data1,
    input  logic [2*wb_pkg::XLEN-1:0]       i_prod0,
    input  logic [2*wb_pkg::XLEN-1:0]       i_prod1,

    // architectural state view
    input  logic [wb_pkg::REG_ADDR_W-1:0]   i_raddr,
    output logic [wb_pkg::XLEN-1:0]         o_rdata,
    output logic [wb_pkg::XLEN-1:0]         o_hi,
    output logic [wb_pkg::XLEN-1:0]         o_lo
);

    logic commit;

    wb_control u_control (
        .clk      (clk),
        .reset    (reset),
        .i_req    (i_req),
        .o_ack    (o_ack),
        .o_commit (commit)
    );

    // HI/LO merge and accumulate
    hilo_unit u_hilo (
        .clk      (clk),
        .reset    (reset),
        .i_commit (commit),
        .i_op0    (i_op0),
        .i_op1    (i_op1),
        .i_data0  (i_data0),
        .i_data1  (i_data1),
        .i_prod0  (i_prod0),
        .i_prod1  (i_prod1),
        .o_hi     (o_hi),
        .o_lo     (o_lo)
    );

    // general registers, one read port
    gpr_file u_gpr (
        .clk      (clk),
        .reset    (reset),
        .i_commit (commit),
        .i_op0    (i_op0),
        .i_op1    (i_op1),
        .i_rdst0  (i_rdst0),
        .i_rdst1  (i_rdst1),
        .i_data0  (i_data0),
        .i_data1  (i_data1),
        .i_raddr  (i_raddr),
        .o_rdata  (o_rdata)
    );

endmodule

// File: bench/tb_wb.sv
`timescale 1ns/10ps

module tb_wb;

    localparam int WAIT_LIMIT = 50;

    logic                            clk;
    logic                            reset;
    logic                            req;
    wb_pkg::wb_op_t                  op0;
    wb_pkg::wb_op_t                  op1;
    logic [wb_pkg::REG_ADDR_W-1:0]   rdst0;
    logic [wb_pkg::REG_ADDR_W-1:0]   rdst1;
    logic [wb_pkg::XLEN-1:0]         data0;
    logic [wb_pkg::XLEN-1:0]         data1;
    logic [2*wb_pkg::XLEN-1:0]       prod0;
    logic [2*wb_pkg::XLEN-1:0]       prod1;
    logic [wb_pkg::REG_ADDR_W-1:0]   raddr;
    logic                            ack;
    logic [wb_pkg::XLEN-1:0]         rdata;
    logic [wb_pkg::XLEN-1:0]         hi;
    logic [wb_pkg::XLEN-1:0]         lo;

    int seed = 32'h21d8;
    int error_count = 0;
    int test_count = 0;
    // expected HI:LO pair tracked across tests
    logic [2*wb_pkg::XLEN-1:0] exp_hilo = '0;

    wb_top UUT (
        .clk     (clk),
        .reset   (reset),
        .i_req   (req),
        .o_ack   (ack),
        .i_op0   (op0),
        .i_op1   (op1),
        .i_rdst0 (rdst0),
        .i_rdst1 (rdst1),
        .i_data0 (data0),
        .i_data1 (data1),
        .i_prod0 (prod0),
        .i_prod1 (prod1),
        .i_raddr (raddr),
        .o_rdata (rdata),
        .o_hi    (hi),
        .o_lo    (lo)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    function automatic logic [63:0] rand_pair();
        rand_pair = {rand_word(), rand_word()};
    endfunction

    task automatic compare_word(input string test_name, input string what,
                                input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Error: %s %s expected %h actual %h", test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_hilo(input string test_name, input logic [63:0] expected);
        compare_word(test_name, "hi", expected[63:32], hi);
        compare_word(test_name, "lo", expected[31:0], lo);
    endtask

    // polls once per falling edge
    task automatic wait_for_ack(input logic level, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (ack !== level && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (ack !== level) begin
            $display("timeout: ack stuck at %b while waiting for %s", ack, what);
            error_count++;
        end
    endtask

    task automatic read_reg(input logic [4:0] addr, output logic [31:0] value);
        @(negedge clk);
        raddr = addr;
        #10;
        value = rdata;
    endtask

    task automatic load_lanes(input wb_pkg::wb_op_t l0_op, input logic [4:0] l0_rdst,
                              input logic [31:0] l0_data, input logic [63:0] l0_prod,
                              input wb_pkg::wb_op_t l1_op, input logic [4:0] l1_rdst,
                              input logic [31:0] l1_data, input logic [63:0] l1_prod);
        op0 = l0_op;
        rdst0 = l0_rdst;
        data0 = l0_data;
        prod0 = l0_prod;
        op1 = l1_op;
        rdst1 = l1_rdst;
        data1 = l1_data;
        prod1 = l1_prod;
    endtask

    // full four-phase exchange
    task automatic send_bundle(input wb_pkg::wb_op_t l0_op, input logic [4:0] l0_rdst,
                               input logic [31:0] l0_data, input logic [63:0] l0_prod,
                               input wb_pkg::wb_op_t l1_op, input logic [4:0] l1_rdst,
                               input logic [31:0] l1_data, input logic [63:0] l1_prod);
        @(negedge clk);
        load_lanes(l0_op, l0_rdst, l0_data, l0_prod, l1_op, l1_rdst, l1_data, l1_prod);
        req = 1'b1;
        wait_for_ack(1'b1, "ack to rise");
        req = 1'b0;
        wait_for_ack(1'b0, "ack to fall");
    endtask

    task automatic end_test(input string test_name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("%s: passed", test_name);
        end else begin
            $display("%s: failed with %0d errors", test_name, error_count - errors_before);
        end
    endtask

    task automatic test_reset_state();
        string name;
        int errors_before;
        logic [31:0] addr;
        logic [31:0] value;
        name = "reset_state";
        errors_before = error_count;
        compare_word(name, "ack", 32'd0, {31'd0, ack});
        check_hilo(name, 64'd0);
        for (int i = 0; i < 8; i++) begin
            addr = rand_word();
            read_reg(addr[4:0], value);
            compare_word(name, "rdata", 32'd0, value);
        end
        end_test(name, errors_before);
    endtask

    task automatic test_gpr_writes();
        string name;
        int errors_before;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] value;
        name = "gpr_writes";
        errors_before = error_count;
        w = rand_word();
        send_bundle(wb_pkg::WB_GPR, 5'd5, w, 64'd0, wb_pkg::WB_NOP, 5'd0, 32'd0, 64'd0);
        read_reg(5'd5, value);
        compare_word(name, "r5", w, value);
        a = rand_word();
        b = rand_word();
        send_bundle(wb_pkg::WB_GPR, 5'd7, a, 64'd0, wb_pkg::WB_GPR, 5'd9, b, 64'd0);
        read_reg(5'd7, value);
        compare_word(name, "r7", a, value);
        read_reg(5'd9, value);
        compare_word(name, "r9", b, value);
        // same target, younger lane stays
        a = rand_word();
        b = rand_word();
        send_bundle(wb_pkg::WB_GPR, 5'd12, a, 64'd0, wb_pkg::WB_GPR, 5'd12, b, 64'd0);
        read_reg(5'd12, value);
        compare_word(name, "r12", b, value);
        a = rand_word();
        b = rand_word();
        send_bundle(wb_pkg::WB_GPR, 5'd0, a, 64'd0, wb_pkg::WB_GPR, 5'd0, b, 64'd0);
        read_reg(5'd0, value);
        compare_word(name, "r0", 32'd0, value);
        read_reg(5'd5, value);
        compare_word(name, "r5 kept", w, value);
        end_test(name, errors_before);
    endtask

    task automatic test_hilo_moves();
        string name;
        int errors_before;
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] p;
        name = "hilo_moves";
        errors_before = error_count;
        a = rand_word();
        b = rand_word();
        send_bundle(wb_pkg::WB_MTHI, 5'd0, a, 64'd0, wb_pkg::WB_MTLO, 5'd0, b, 64'd0);
        exp_hilo = {a, b};
        check_hilo(name, exp_hilo);
        p = rand_pair();
        send_bundle(wb_pkg::WB_MULT, 5'd0, 32'd0, p, wb_pkg::WB_NOP, 5'd0, 32'd0, 64'd0);
        exp_hilo = p;
        check_hilo(name, exp_hilo);
        // HI from lane 1, LO from the lane 0 product
        p = rand_pair();
        a = rand_word();
        send_bundle(wb_pkg::WB_MULT, 5'd0, 32'd0, p, wb_pkg::WB_MTHI, 5'd0, a, 64'd0);
        exp_hilo = {a, p[31:0]};
        check_hilo(name, exp_hilo);
        end_test(name, errors_before);
    endtask

    task automatic test_accumulate();
        string name;
        int errors_before;
        logic [63:0] q;
        logic [63:0] r;
        name = "accumulate";
        errors_before = error_count;
        q = rand_pair();
        send_bundle(wb_pkg::WB_MULT, 5'd0, 32'd0, q, wb_pkg::WB_NOP, 5'd0, 32'd0, 64'd0);
        exp_hilo = q;
        check_hilo(name, exp_hilo);
        q = rand_pair();
        send_bundle(wb_pkg::WB_MADD, 5'd0, 32'd0, q, wb_pkg::WB_NOP, 5'd0, 32'd0, 64'd0);
        exp_hilo = exp_hilo + q;
        check_hilo(name, exp_hilo);
        q = rand_pair();
        send_bundle(wb_pkg::WB_MSUB, 5'd0, 32'd0, q, wb_pkg::WB_NOP, 5'd0, 32'd0, 64'd0);
        exp_hilo = exp_hilo - q;
        check_hilo(name, exp_hilo);
        // both lanes see the old pair, lane 1 result is kept
        q = rand_pair();
        r = rand_pair();
        send_bundle(wb_pkg::WB_MADD, 5'd0, 32'd0, q, wb_pkg::WB_MSUB, 5'd0, 32'd0, r);
        exp_hilo = exp_hilo - r;
        check_hilo(name, exp_hilo);
        q = rand_pair();
        r = rand_pair();
        send_bundle(wb_pkg::WB_MSUB, 5'd0, 32'd0, q, wb_pkg::WB_MADD, 5'd0, 32'd0, r);
        exp_hilo = exp_hilo + r;
        check_hilo(name, exp_hilo);
        end_test(name, errors_before);
    endtask

    task automatic test_handshake();
        string name;
        int errors_before;
        logic [63:0] p;
        name = "handshake";
        errors_before = error_count;
        compare_word(name, "ack idle", 32'd0, {31'd0, ack});
        p = rand_pair();
        exp_hilo = exp_hilo + p;
        @(negedge clk);
        load_lanes(wb_pkg::WB_MADD, 5'd0, 32'd0, p, wb_pkg::WB_NOP, 5'd0, 32'd0, 64'd0);
        req = 1'b1;
        // still in the commit cycle here
        @(negedge clk);
        compare_word(name, "ack in commit", 32'd0, {31'd0, ack});
        wait_for_ack(1'b1, "ack to rise");
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            compare_word(name, "ack held", 32'd1, {31'd0, ack});
            check_hilo(name, exp_hilo);
        end
        req = 1'b0;
        wait_for_ack(1'b0, "ack to fall");
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            compare_word(name, "ack after drop", 32'd0, {31'd0, ack});
            check_hilo(name, exp_hilo);
        end
        end_test(name, errors_before);
    endtask

    initial begin
        reset = 1'b1;
        req = 1'b0;
        raddr = '0;
        load_lanes(wb_pkg::WB_NOP, 5'd0, 32'd0, 64'd0, wb_pkg::WB_NOP, 5'd0, 32'd0, 64'd0);
        repeat (8) @(negedge clk);
        reset = 1'b0;

        test_reset_state();
        test_gpr_writes();
        test_hilo_moves();
        test_accumulate();
        test_handshake();

        $display("summary: %0d tests run, %0d errors", test_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
rtl/wb_pkg.sv
rtl/wb_control.sv
rtl/hilo_unit.sv
rtl/gpr_file.sv
rtl/wb_top.sv
bench/tb_wb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_wb
RTL_TOP   ?= wb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

RTL_SRCS  ?= rtl/wb_pkg.sv rtl/wb_control.sv rtl/hilo_unit.sv rtl/gpr_file.sv rtl/wb_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) || (echo "simulation did not pass" && exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
